//--- src.f
logic/maxnetPkg.sv
logic/inhibitionLayer.sv
logic/winnerSelect.sv
logic/maxnetController.sv
logic/maxnetDatapath.sv
logic/maxnetTop.sv
testbench/maxnetChecker.sv
testbench/maxnetTb.sv

//--- testbench/maxnetTb.sv
`timescale 1ns/1ps

module maxnetTb
    import maxnetPkg::*;
();

    localparam int clockPeriod = 100;
    localparam int randomRuns  = 200;
    localparam int tieRuns     = 12;
    localparam int totalRuns   = randomRuns + tieRuns + 2;

    // Worst run is maxIterations updates plus load, finish and an idle cycle.
    localparam int watchdogCycles = totalRuns * (maxIterations + 4) + 50;

    logic                 clk;
    logic                 rstN;
    logic                 start;
    laneVec               inputs;
    logic                 done;
    logic                 busy;
    laneIndex             winner;
    logic [dataWidth-1:0] maxNumber;
    logic                 noWinner;

    logic [15:0] lfsrState;
    int          expectedRuns;
    int          expectedIgnored;
    laneVec      vec;
    laneVec      firstVec;

    maxnetTop uut (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .inputs    (inputs),
        .done      (done),
        .busy      (busy),
        .winner    (winner),
        .maxNumber (maxNumber),
        .noWinner  (noWinner)
    );

    maxnetChecker resultChecker (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .inputs    (inputs),
        .done      (done),
        .busy      (busy),
        .winner    (winner),
        .maxNumber (maxNumber),
        .noWinner  (noWinner)
    );

    initial begin
        clk = 1'b0;
        forever #(clockPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogCycles * clockPeriod);
        $display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawBits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            bits      = {bits[30:0], lfsrState[0]};
        end
    endtask

    task automatic makeRandomVector(output laneVec v);
        logic [31:0] bits;
        drawBits(16, bits);
        v.lane0 = bits;
        drawBits(16, bits);
        v.lane1 = bits;
        drawBits(16, bits);
        v.lane2 = bits;
        drawBits(16, bits);
        v.lane3 = bits;
    endtask

    // Two lanes share the largest value, the rest stay below it.
    task automatic makeTieVector(output laneVec v);
        logic [31:0]          top;
        logic [31:0]          bits;
        logic [31:0]          firstLane;
        logic [31:0]          offset;
        logic [dataWidth-1:0] lanes [laneCount];
        int                   first;
        int                   second;
        drawBits(16, top);
        if (top == 0) begin
            top = 1;
        end
        drawBits(2, firstLane);
        drawBits(1, offset);
        first  = firstLane;
        second = (first + 1 + offset) % laneCount;
        for (int i = 0; i < laneCount; i++) begin
            drawBits(16, bits);
            lanes[i] = (bits < top) ? bits : (top >> 1);
        end
        lanes[first]  = top;
        lanes[second] = top;
        v.lane0 = lanes[0];
        v.lane1 = lanes[1];
        v.lane2 = lanes[2];
        v.lane3 = lanes[3];
    endtask

    task automatic runVector(input laneVec v);
        @(negedge clk);
        start  = 1'b1;
        inputs = v;
        expectedRuns++;
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            @(negedge clk);
        end
    endtask

    // The second pulse lands while the first run is still iterating.
    task automatic startWhileBusy(input laneVec v, input laneVec other);
        @(negedge clk);
        start  = 1'b1;
        inputs = v;
        expectedRuns++;
        @(negedge clk);
        start = 1'b0;
        @(negedge clk);
        start  = 1'b1;
        inputs = other;
        expectedIgnored++;
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            @(negedge clk);
        end
    endtask

    initial begin
        rstN            = 1'b0;
        start           = 1'b0;
        inputs          = '0;
        lfsrState       = 16'd2;
        expectedRuns    = 0;
        expectedIgnored = 0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;

        for (int n = 0; n < randomRuns; n++) begin
            makeRandomVector(vec);
            runVector(vec);
        end

        for (int n = 0; n < tieRuns; n++) begin
            makeTieVector(vec);
            runVector(vec);
        end

        // Wide spread, so several updates are needed before done.
        firstVec.lane0 = 40000;
        firstVec.lane1 = 30000;
        firstVec.lane2 = 20000;
        firstVec.lane3 = 10000;
        makeRandomVector(vec);
        startWhileBusy(firstVec, vec);

        runVector('0);

        repeat (4) @(negedge clk);
        resultChecker.compareRunCount(expectedRuns);
        resultChecker.compareIgnoredStarts(expectedIgnored);

        $display("Tests run: %0d, errors: %0d", resultChecker.testCount,
                 resultChecker.errorCount);
        if (resultChecker.errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- testbench/maxnetChecker.sv
`timescale 1ns/1ps

module maxnetChecker
    import maxnetPkg::*;
(
    input logic                 clk,
    input logic                 rstN,
    input logic                 start,
    input laneVec               inputs,
    input logic                 done,
    input logic                 busy,
    input laneIndex             winner,
    input logic [dataWidth-1:0] maxNumber,
    input logic                 noWinner
);

    int testCount     = 0;
    int errorCount    = 0;
    int runCount      = 0;
    int ignoredStarts = 0;
    int runErrors     = 0;

    logic resetChecked = 1'b0;
    logic pending      = 1'b0;

    // Prediction for the run in progress.
    int                   cycleCount;
    int                   expUpdates;
    laneIndex             expWinner;
    logic [dataWidth-1:0] expMax;
    logic                 expNoWinner;
    logic                 expConverged;
    logic [dataWidth-1:0] largest;
    logic                 uniqueLargest;

    function automatic logic [dataWidth-1:0] laneValue(input laneVec vec, input int i);
        case (i)
            0:       return vec.lane0;
            1:       return vec.lane1;
            2:       return vec.lane2;
            default: return vec.lane3;
        endcase
    endfunction

    function automatic void findLargest(input laneVec vec, output logic [dataWidth-1:0] value,
                                        output logic isUnique);
        logic [dataWidth-1:0] v;
        value    = vec.lane0;
        isUnique = 1'b1;
        for (int i = 1; i < laneCount; i++) begin
            v = laneValue(vec, i);
            if (v > value) begin
                value    = v;
                isUnique = 1'b1;
            end else if (v == value) begin
                isUnique = 1'b0;
            end
        end
    endfunction

    // Each lane loses an eighth of the others' sum and is clipped at zero.
    function automatic void runModel(input laneVec vec, output int updates,
                                     output laneIndex win, output logic [dataWidth-1:0] maxVal,
                                     output logic empty, output logic converged);
        longint act [laneCount];
        longint nxt [laneCount];
        longint total;
        int     live;
        for (int i = 0; i < laneCount; i++) begin
            act[i] = laneValue(vec, i);
        end
        updates = 0;
        while (1) begin
            live = 0;
            for (int i = 0; i < laneCount; i++) begin
                if (act[i] != 0) begin
                    live++;
                end
            end
            if (live <= 1 || updates >= maxIterations) begin
                break;
            end
            total = 0;
            for (int i = 0; i < laneCount; i++) begin
                total += act[i];
            end
            for (int i = 0; i < laneCount; i++) begin
                nxt[i] = act[i] - (total - act[i]) / (longint'(1) << inhibitShift);
                if (nxt[i] < 0) begin
                    nxt[i] = 0;
                end
            end
            for (int i = 0; i < laneCount; i++) begin
                act[i] = nxt[i];
            end
            updates++;
        end
        converged = (live <= 1);
        empty     = 1'b1;
        win       = '0;
        maxVal    = '0;
        for (int i = 0; i < laneCount; i++) begin
            if (empty && act[i] != 0) begin
                empty  = 1'b0;
                win    = laneIndex'(i);
                maxVal = laneValue(vec, i);
            end
        end
    endfunction

    task automatic checkValue(input string name, input logic [dataWidth-1:0] expected,
                              input logic [dataWidth-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, expected, actual);
            runErrors++;
        end
    endtask

    task automatic reportFailure(input string what);
        $display("Test %0d: %s", testCount + 1, what);
        runErrors++;
    endtask

    task automatic finishTest(input string detail);
        testCount++;
        errorCount += runErrors;
        if (runErrors == 0) begin
            $display("Test %0d passed: %s", testCount, detail);
        end else begin
            $display("Test %0d failed: %s", testCount, detail);
        end
        runErrors = 0;
    endtask

    task automatic compareRunCount(input int expected);
        if (runCount != expected) begin
            $display("Saw %0d done strobes, but %0d runs were started", runCount, expected);
            errorCount++;
        end
    endtask

    task automatic compareIgnoredStarts(input int expected);
        if (ignoredStarts != expected) begin
            $display("Saw %0d ignored start pulses, but %0d were sent while busy",
                     ignoredStarts, expected);
            errorCount++;
        end
    endtask

    always @(posedge clk) begin
        if (rstN) begin
            if (!resetChecked) begin
                checkValue("done", '0, done);
                checkValue("busy", '0, busy);
                checkValue("winner", '0, winner);
                checkValue("maxNumber", '0, maxNumber);
                checkValue("noWinner", '0, noWinner);
                resetChecked = 1'b1;
                finishTest("outputs after reset");
            end

            if (pending) begin
                cycleCount++;
                if (!busy) begin
                    reportFailure("busy was low while a run was in progress");
                end
                if (done) begin
                    if (cycleCount != expUpdates + 2) begin
                        reportFailure($sformatf("done came %0d cycles after start, expected %0d",
                                                cycleCount, expUpdates + 2));
                    end
                    checkValue("winner", expWinner, winner);
                    checkValue("maxNumber", expMax, maxNumber);
                    checkValue("noWinner", expNoWinner, noWinner);
                    // A settled run with one clear maximum must report that maximum.
                    if (expConverged && uniqueLargest) begin
                        checkValue("maxNumber", largest, maxNumber);
                    end
                    runCount++;
                    pending = 1'b0;
                    finishTest($sformatf("%0d updates, winner %0d, maxNumber 0x%h, noWinner %0d",
                                         expUpdates, expWinner, expMax, expNoWinner));
                end else if (cycleCount == expUpdates + 2) begin
                    reportFailure("done did not arrive on time");
                end
            end else if (done) begin
                reportFailure("done pulsed with no run in progress");
                errorCount += runErrors;
                runErrors = 0;
            end

            if (start) begin
                if (!busy) begin
                    runModel(inputs, expUpdates, expWinner, expMax, expNoWinner, expConverged);
                    findLargest(inputs, largest, uniqueLargest);
                    cycleCount = 0;
                    runErrors  = 0;
                    pending    = 1'b1;
                end else begin
                    ignoredStarts++;
                    $display("Start while busy is expected to be ignored");
                end
            end
        end
    end

endmodule

//--- logic/maxnetTop.sv
`timescale 1ns/1ps

module maxnetTop
    import maxnetPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 start,
    input  laneVec               inputs,
    output logic                 done,
    output logic                 busy,
    output laneIndex             winner,
    output logic [dataWidth-1:0] maxNumber,
    output logic                 noWinner
);

    logic loadInputs;
    logic iterate;
    logic settled;

    maxnetController controller (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .settled    (settled),
        .loadInputs (loadInputs),
        .iterate    (iterate),
        .busy       (busy),
        .done       (done)
    );

    maxnetDatapath datapath (
        .clk        (clk),
        .rstN       (rstN),
        .loadInputs (loadInputs),
        .iterate    (iterate),
        .inputs     (inputs),
        .settled    (settled),
        .winner     (winner),
        .maxNumber  (maxNumber),
        .noWinner   (noWinner)
    );

endmodule

//--- logic/maxnetDatapath.sv
`timescale 1ns/1ps

module maxnetDatapath
    import maxnetPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 loadInputs,
    input  logic                 iterate,
    input  laneVec               inputs,
    output logic                 settled,
    output laneIndex             winner,
    output logic [dataWidth-1:0] maxNumber,
    output logic                 noWinner
);

    laneVec originals;
    laneVec activations;
    laneVec nextActivations;
    logic   allZero;

    // Set once a vector has been taken in.
    logic   vectorLoaded;

    // Originals are held for the whole run for the final lookup.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            originals <= '0;
        end else if (loadInputs) begin
            originals <= inputs;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            activations <= '0;
        end else if (loadInputs) begin
            activations <= inputs;
        end else if (iterate) begin
            activations <= nextActivations;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            vectorLoaded <= 1'b0;
        end else if (loadInputs) begin
            vectorLoaded <= 1'b1;
        end
    end

    inhibitionLayer layer (
        .activations     (activations),
        .nextActivations (nextActivations)
    );

    winnerSelect select (
        .activations (activations),
        .originals   (originals),
        .settled     (settled),
        .winner      (winner),
        .maxNumber   (maxNumber),
        .noWinner    (allZero)
    );

    // The zeroed banks after reset are not a real empty result.
    assign noWinner = allZero & vectorLoaded;

endmodule

//--- logic/maxnetController.sv
`timescale 1ns/1ps

module maxnetController
    import maxnetPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic settled,
    output logic loadInputs,
    output logic iterate,
    output logic busy,
    output logic done
);

    maxnetState           state;
    maxnetState           nextState;
    logic [iterWidth-1:0] iterCount;
    logic                 limitReached;

    assign limitReached = (iterCount >= iterWidth'(maxIterations));

    always_comb begin
        nextState  = state;
        loadInputs = 1'b0;
        iterate    = 1'b0;

        case (state)
            IDLE: begin
                // A start seen outside IDLE is simply dropped.
                if (start) begin
                    loadInputs = 1'b1;
                    nextState  = ITERATE;
                end
            end

            ITERATE: begin
                if (!settled && !limitReached) begin
                    iterate = 1'b1;
                end else begin
                    nextState = FINISH;
                end
            end

            FINISH: begin
                nextState = IDLE;
            end

            default: begin
                nextState = IDLE;
            end
        endcase
    end

    assign done = (state == FINISH);
    assign busy = (state != IDLE);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Counts updates of the current run.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            iterCount <= '0;
        end else if (loadInputs) begin
            iterCount <= '0;
        end else if (iterate) begin
            iterCount <= iterCount + 1'b1;
        end
    end

endmodule

//--- logic/winnerSelect.sv
`timescale 1ns/1ps

module winnerSelect
    import maxnetPkg::*;
(
    input  laneVec                activations,
    input  laneVec                originals,
    output logic                  settled,
    output laneIndex              winner,
    output logic [dataWidth-1:0]  maxNumber,
    output logic                  noWinner
);

    logic [laneCount-1:0][dataWidth-1:0] current;
    logic [laneCount-1:0][dataWidth-1:0] held;
    logic [laneCount-1:0]                nonZero;
    logic [$clog2(laneCount+1)-1:0]      liveCount;

    assign current = activations;
    assign held    = originals;

    for (genvar lane = 0; lane < laneCount; lane++) begin : gFlag
        assign nonZero[lane] = |current[lane];
    end

    always_comb begin
        liveCount = '0;
        for (int i = 0; i < laneCount; i++) begin
            liveCount = liveCount + ($clog2(laneCount+1))'(nonZero[i]);
        end
    end

    assign settled = (liveCount <= 1);

    // Walk down so that the lowest nonzero lane is the one kept.
    always_comb begin
        winner = '0;
        for (int i = laneCount - 1; i >= 0; i--) begin
            if (nonZero[i]) begin
                winner = laneIndex'(i);
            end
        end
    end

    assign noWinner  = ~|nonZero;
    assign maxNumber = noWinner ? '0 : held[winner];

endmodule

//--- logic/inhibitionLayer.sv
`timescale 1ns/1ps

module inhibitionLayer
    import maxnetPkg::*;
(
    input  laneVec activations,
    output laneVec nextActivations
);

    logic [laneCount-1:0][dataWidth-1:0] current;
    logic [laneCount-1:0][dataWidth-1:0] updated;
    logic [sumWidth-1:0]                 total;

    assign current = activations;

    // Sum of every lane, shared by all the inhibition terms.
    always_comb begin
        total = '0;
        for (int i = 0; i < laneCount; i++) begin
            total = total + sumWidth'(current[i]);
        end
    end

    // Each lane keeps its own weight of one and takes minus epsilon
    // from each of the others.
    for (genvar lane = 0; lane < laneCount; lane++) begin : gLane
        logic [sumWidth-1:0]      others;
        logic [sumWidth-1:0]      inhibition;
        logic [sumWidth-1:0]      own;
        logic signed [sumWidth:0] difference;

        assign own        = sumWidth'(current[lane]);
        assign others     = total - own;
        assign inhibition = others >> inhibitShift;

        // Both operands are nonnegative, so one guard bit gives the sign.
        assign difference = $signed({1'b0, own}) - $signed({1'b0, inhibition});

        // ReLU.
        assign updated[lane] = difference[sumWidth] ? '0 : difference[dataWidth-1:0];
    end

    assign nextActivations = updated;

endmodule

//--- logic/maxnetPkg.sv
package maxnetPkg;

    // Number of competing lanes.
    localparam int laneCount = 4;

    // Width of the inputs and of the activations.
    localparam int dataWidth = 32;

    // Epsilon is 2**-inhibitShift, so one eighth.
    localparam int inhibitShift = 3;

    // Updates allowed before the run gives up.
    localparam int maxIterations = 64;

    // Room for the sum of all lanes without overflow.
    localparam int sumWidth = dataWidth + $clog2(laneCount);

    // Iteration counter must reach maxIterations itself.
    localparam int iterWidth = $clog2(maxIterations + 1);

    // Lane 3 sits in the top bits so that a packed array view
    // of this struct puts lane i at index i.
    typedef struct packed {
        logic [dataWidth-1:0] lane3;
        logic [dataWidth-1:0] lane2;
        logic [dataWidth-1:0] lane1;
        logic [dataWidth-1:0] lane0;
    } laneVec;

    typedef enum logic [1:0] {
        IDLE,
        ITERATE,
        FINISH
    } maxnetState;

    typedef logic [$clog2(laneCount)-1:0] laneIndex;

endpackage
